//--- verilog/cpu_pkg.sv
// core package with word types, decode enums, forwarding selects and reset values
package cpu_pkg;

    typedef logic [31:0] word_t;     // data and address word
    typedef logic [4:0]  reg_addr_t; // register index

    // RV32I major opcodes in the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        SLT
    } alu_op_e;

    // operand source for execute
    typedef enum logic [1:0] {
        BP_NONE,
        BP_MEM,
        BP_WB
    } bypass_e;

    // data memory four-phase handshake
    typedef enum logic [1:0] {
        M_IDLE,
        M_REQ,     // req high, waiting for ack
        M_RELEASE  // req low, waiting for ack to drop
    } mem_state_e;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

endpackage : cpu_pkg

//--- verilog/de_bus_if.sv
// decode to execute bundle, one decoded instruction per cycle
`timescale 1ns/1ps

interface de_bus_if;
    import cpu_pkg::*;

    word_t     rd1;     // register operands
    word_t     rd2;
    word_t     imm;
    alu_op_e   alu_op;
    logic      src_imm; // operand b from imm
    reg_addr_t ra1;
    reg_addr_t ra2;
    reg_addr_t wa;
    logic      we_rf;
    logic      we_dm;
    logic      is_load;

    modport decode (
        output rd1, rd2, imm, alu_op, src_imm, ra1, ra2, wa, we_rf, we_dm, is_load
    );

    modport exec (
        input rd1, rd2, imm, alu_op, src_imm, ra1, ra2, wa, we_rf, we_dm, is_load
    );

    // hazard detection only looks at indices and write controls
    modport hazard (
        input ra1, ra2, wa, we_rf, is_load
    );

endinterface : de_bus_if

//--- verilog/fetch_unit.sv
// instruction fetch with program counter, branch redirect and fetch-to-decode register
`timescale 1ns/1ps

module fetch_unit
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall_if,
    input  logic           flush_id,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_data,
    output cpu_pkg::word_t pc_id,
    output cpu_pkg::word_t instr_id
);
    import cpu_pkg::*;

    word_t pc_if;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            pc_if <= RESET_PC;
        else if (!stall_if)
            pc_if <= branch_taken ? branch_target : pc_if + 32'd4;
    end

    assign imem_addr = pc_if; // word arrives before the next edge

    // taken branch kills the word fetched behind it
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            instr_id <= NOP_INSTR;
        else if (flush_id)
            instr_id <= NOP_INSTR;
        else if (!stall_if)
            instr_id <= imem_data;
    end

    always_ff @(posedge clk)
    begin
        if (!stall_if)
            pc_id <= pc_if;
    end

endmodule : fetch_unit

//--- verilog/decode_unit.sv
// instruction decode with register file, branch resolution and decode-to-execute register
`timescale 1ns/1ps

module decode_unit
(
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     pc_id,
    input  cpu_pkg::word_t     instr_id,
    input  logic               stall_id,
    input  logic               flush_ex,
    input  logic               stall_ex,
    input  logic               cmp_fwd_a,
    input  logic               cmp_fwd_b,
    input  cpu_pkg::word_t     alu_res_mem,
    input  cpu_pkg::reg_addr_t wa_wb,
    input  cpu_pkg::word_t     wd_wb,
    input  logic               we_wb,
    input  cpu_pkg::reg_addr_t dbg_addr,
    output cpu_pkg::word_t     dbg_data,
    output cpu_pkg::reg_addr_t ra1_id,
    output cpu_pkg::reg_addr_t ra2_id,
    output logic               uses_rs2,
    output logic               is_branch,
    output logic               branch_taken,
    output cpu_pkg::word_t     branch_target,
    output logic               flush_id,
    de_bus_if.decode           de
);
    import cpu_pkg::*;

    word_t   rf [32];
    opcode_e opcode;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_id;
    alu_op_e alu_op_id;
    logic    src_imm_id;
    logic    we_rf_id;
    logic    we_dm_id;
    logic    is_load_id;
    word_t   rd1_id;
    word_t   rd2_id;
    word_t   cmp_a;
    word_t   cmp_b;

    function automatic alu_op_e alu_decode(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  alu_decode = sub ? SUB : ADD;
            3'b010:  alu_decode = SLT;
            3'b110:  alu_decode = OR;
            3'b111:  alu_decode = AND;
            default: alu_decode = ADD;
        endcase
    endfunction

    // x0 reads zero, a same-cycle writeback is passed through
    function automatic word_t rf_read(input reg_addr_t ra);
        if (ra == '0)
            rf_read = '0;
        else if (we_wb && wa_wb == ra)
            rf_read = wd_wb;
        else
            rf_read = rf[ra];
    endfunction

    assign opcode = opcode_e'(instr_id[6:0]);
    assign ra1_id = instr_id[19:15];
    assign ra2_id = instr_id[24:20];
    assign imm_i  = {{20{instr_id[31]}}, instr_id[31:20]};
    assign imm_s  = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
    assign imm_b  = {{19{instr_id[31]}}, instr_id[31], instr_id[7], instr_id[30:25],
                     instr_id[11:8], 1'b0};

    always_comb
    begin
        alu_op_id  = ADD;
        imm_id     = imm_i;
        src_imm_id = 1'b0;
        we_rf_id   = 1'b0;
        we_dm_id   = 1'b0;
        is_load_id = 1'b0;
        uses_rs2   = 1'b0;
        is_branch  = 1'b0;
        case (opcode)
            OP:
            begin
                we_rf_id  = 1'b1;
                uses_rs2  = 1'b1;
                alu_op_id = alu_decode(instr_id[14:12], instr_id[30]); // funct7 bit for sub
            end
            OP_IMM:
            begin
                we_rf_id   = 1'b1;
                src_imm_id = 1'b1;
                alu_op_id  = alu_decode(instr_id[14:12], 1'b0);
            end
            LOAD:
            begin
                we_rf_id   = 1'b1;
                src_imm_id = 1'b1;
                is_load_id = 1'b1;
            end
            STORE:
            begin
                we_dm_id   = 1'b1;
                src_imm_id = 1'b1;
                uses_rs2   = 1'b1;
                imm_id     = imm_s;
            end
            BRANCH:
            begin
                is_branch = 1'b1;
                uses_rs2  = 1'b1;
            end
            default: ; // anything else behaves as a nop
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (we_wb && wa_wb != '0)
            rf[wa_wb] <= wd_wb;
    end

    always_comb
    begin
        rd1_id   = rf_read(ra1_id);
        rd2_id   = rf_read(ra2_id);
        dbg_data = rf_read(dbg_addr);
    end

    // beq when funct3[0] low, bne when high
    assign cmp_a         = cmp_fwd_a ? alu_res_mem : rd1_id;
    assign cmp_b         = cmp_fwd_b ? alu_res_mem : rd2_id;
    assign branch_taken  = is_branch && (instr_id[12] ? (cmp_a != cmp_b) : (cmp_a == cmp_b));
    assign branch_target = pc_id + imm_b;
    assign flush_id      = branch_taken && !stall_id;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            de.we_rf   <= 1'b0;
            de.we_dm   <= 1'b0;
            de.is_load <= 1'b0;
        end
        else if (!stall_ex)
        begin
            de.we_rf   <= we_rf_id && !flush_ex;
            de.we_dm   <= we_dm_id && !flush_ex;
            de.is_load <= is_load_id && !flush_ex;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_ex)
        begin
            de.rd1     <= rd1_id;
            de.rd2     <= rd2_id;
            de.imm     <= imm_id;
            de.alu_op  <= alu_op_id;
            de.src_imm <= src_imm_id;
            de.ra1     <= ra1_id;
            de.ra2     <= ra2_id;
            de.wa      <= instr_id[11:7];
        end
    end

endmodule : decode_unit

//--- verilog/exec_unit.sv
// execute stage with operand forwarding, ALU and execute-to-memory register
`timescale 1ns/1ps

module exec_unit
(
    input  logic               clk,
    input  logic               arst_n,
    de_bus_if.exec             de,
    input  cpu_pkg::bypass_e   fwd_a,
    input  cpu_pkg::bypass_e   fwd_b,
    input  cpu_pkg::word_t     alu_res_fb,
    input  cpu_pkg::word_t     wd_wb,
    input  logic               stall_mem,
    output cpu_pkg::word_t     alu_res_mem,
    output cpu_pkg::word_t     store_data_mem,
    output cpu_pkg::reg_addr_t wa_mem,
    output logic               we_rf_mem,
    output logic               we_dm_mem,
    output logic               is_load_mem
);
    import cpu_pkg::*;

    logic  held;     // previous cycle was a memory stall
    word_t a_fwd;
    word_t b_fwd;
    word_t a_hold;
    word_t b_hold;
    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t result;

    function automatic word_t fwd_mux(input bypass_e sel, input word_t rf_val);
        case (sel)
            BP_MEM:  fwd_mux = alu_res_fb;
            BP_WB:   fwd_mux = wd_wb;
            default: fwd_mux = rf_val;
        endcase
    endfunction

    always_comb
    begin
        a_fwd = fwd_mux(fwd_a, de.rd1);
        b_fwd = fwd_mux(fwd_b, de.rd2);
    end

    // writeback drains during a stall, keep the operands seen in its first cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            held <= 1'b0;
        else
            held <= stall_mem;
    end

    always_ff @(posedge clk)
    begin
        if (!held)
        begin
            a_hold <= a_fwd;
            b_hold <= b_fwd;
        end
    end

    assign op_a  = held ? a_hold : a_fwd;
    assign op_b  = held ? b_hold : b_fwd;
    assign alu_b = de.src_imm ? de.imm : op_b;

    always_comb
    begin
        case (de.alu_op)
            SUB:     result = op_a - alu_b;
            AND:     result = op_a & alu_b;
            OR:      result = op_a | alu_b;
            SLT:     result = {31'b0, $signed(op_a) < $signed(alu_b)};
            default: result = op_a + alu_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            we_rf_mem   <= 1'b0;
            we_dm_mem   <= 1'b0;
            is_load_mem <= 1'b0;
        end
        else if (!stall_mem)
        begin
            we_rf_mem   <= de.we_rf;
            we_dm_mem   <= de.we_dm;
            is_load_mem <= de.is_load;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_mem)
        begin
            alu_res_mem    <= result;
            store_data_mem <= op_b;  // rs2 after forwarding
            wa_mem         <= de.wa;
        end
    end

endmodule : exec_unit

//--- verilog/memwb_unit.sv
// memory stage outputs, load capture and memory-to-writeback register
`timescale 1ns/1ps

module memwb_unit
(
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::word_t     alu_res_mem,
    input  cpu_pkg::word_t     store_data_mem,
    input  cpu_pkg::reg_addr_t wa_mem,
    input  logic               we_rf_mem,
    input  logic               we_dm_mem,
    input  logic               is_load_mem,
    input  logic               mem_done,
    input  logic               dmem_ack,
    input  cpu_pkg::word_t     dmem_rdata,
    output cpu_pkg::word_t     dmem_addr,
    output cpu_pkg::word_t     dmem_wdata,
    output logic               dmem_we,
    output logic               mem_access,
    output cpu_pkg::reg_addr_t wa_wb,
    output cpu_pkg::word_t     wd_wb,
    output logic               we_wb
);
    import cpu_pkg::*;

    logic  ack_q;
    word_t load_data;
    logic  advance;

    assign dmem_addr  = alu_res_mem;
    assign dmem_wdata = store_data_mem;
    assign dmem_we    = we_dm_mem;
    assign mem_access = we_dm_mem || is_load_mem;
    assign advance    = !mem_access || mem_done;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ack_q <= 1'b0;
            we_wb <= 1'b0;
        end
        else
        begin
            ack_q <= dmem_ack;
            we_wb <= advance && we_rf_mem; // bubble while the access is open
        end
    end

    always_ff @(posedge clk)
    begin
        if (dmem_ack && !ack_q)
            load_data <= dmem_rdata; // first cycle of ack
        if (advance)
        begin
            wa_wb <= wa_mem;
            wd_wb <= is_load_mem ? load_data : alu_res_mem;
        end
    end

endmodule : memwb_unit

//--- verilog/hazard_ctrl.sv
// pipeline control with forwarding selects, stalls and the data memory handshake FSM
`timescale 1ns/1ps

module hazard_ctrl
(
    input  logic               clk,
    input  logic               arst_n,
    de_bus_if.hazard           de,
    input  cpu_pkg::reg_addr_t ra1_id,
    input  cpu_pkg::reg_addr_t ra2_id,
    input  logic               uses_rs2,
    input  logic               is_branch,
    input  cpu_pkg::reg_addr_t wa_mem,
    input  logic               we_rf_mem,
    input  logic               mem_access,
    input  cpu_pkg::reg_addr_t wa_wb,
    input  logic               we_rf_wb,
    input  logic               dmem_ack,
    output logic               dmem_req,
    output logic               mem_done,
    output cpu_pkg::bypass_e   fwd_a,
    output cpu_pkg::bypass_e   fwd_b,
    output logic               cmp_fwd_a,
    output logic               cmp_fwd_b,
    output logic               stall_if,
    output logic               stall_id,
    output logic               stall_ex,
    output logic               stall_mem,
    output logic               flush_ex
);
    import cpu_pkg::*;

    mem_state_e mem_state;
    mem_state_e mem_state_nxt;
    logic       mem_stall;
    logic       alu_in_mem;  // memory stage holds an ALU result
    logic       load_use;
    logic       br_dep;

    // does a writer at wa collide with the decode-stage sources
    function automatic logic id_hit(input reg_addr_t wa, input logic we);
        id_hit = we && (wa != '0) && ((wa == ra1_id) || (uses_rs2 && (wa == ra2_id)));
    endfunction

    assign alu_in_mem = we_rf_mem && !mem_access;

    // execute operand selects, x0 never forwarded
    always_comb
    begin
        fwd_a = BP_NONE;
        fwd_b = BP_NONE;
        if (alu_in_mem && wa_mem != '0 && wa_mem == de.ra1)
            fwd_a = BP_MEM;
        else if (we_rf_wb && wa_wb != '0 && wa_wb == de.ra1)
            fwd_a = BP_WB;
        if (alu_in_mem && wa_mem != '0 && wa_mem == de.ra2)
            fwd_b = BP_MEM;
        else if (we_rf_wb && wa_wb != '0 && wa_wb == de.ra2)
            fwd_b = BP_WB;
    end

    // comparator only bypasses from memory, writeback goes through the regfile
    assign cmp_fwd_a = alu_in_mem && (wa_mem != '0) && (wa_mem == ra1_id);
    assign cmp_fwd_b = alu_in_mem && (wa_mem != '0) && (wa_mem == ra2_id);

    always_comb
    begin
        load_use = de.is_load && id_hit(de.wa, 1'b1);
        br_dep   = is_branch && (id_hit(de.wa, de.we_rf) ||
                                 id_hit(wa_mem, we_rf_mem && mem_access));
    end

    always_comb
    begin
        mem_state_nxt = mem_state;
        case (mem_state)
            M_IDLE:    if (mem_access && !dmem_ack) mem_state_nxt = M_REQ;
            M_REQ:     if (dmem_ack) mem_state_nxt = M_RELEASE;
            M_RELEASE: if (!dmem_ack) mem_state_nxt = M_IDLE;
            default:   mem_state_nxt = M_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            mem_state <= M_IDLE;
        else
            mem_state <= mem_state_nxt;
    end

    assign dmem_req  = (mem_state == M_REQ);
    assign mem_done  = (mem_state == M_RELEASE) && !dmem_ack; // one cycle, ack seen low
    assign mem_stall = mem_access && !mem_done;

    assign stall_if  = mem_stall || load_use || br_dep;
    assign stall_id  = stall_if;
    assign stall_ex  = mem_stall;
    assign stall_mem = mem_stall;
    assign flush_ex  = (load_use || br_dep) && !mem_stall; // bubble only if execute moves

endmodule : hazard_ctrl

//--- verilog/cpu_top.sv
// five-stage pipelined RV32I subset core, stage and control wiring
`timescale 1ns/1ps

module cpu_top
(
    input  logic              clk,
    input  logic              arst_n,
    // instruction memory
    output cpu_pkg::word_t    imem_addr,
    input  cpu_pkg::word_t    imem_data,
    // data memory, four-phase req/ack
    output cpu_pkg::word_t    dmem_addr,
    output cpu_pkg::word_t    dmem_wdata,
    input  cpu_pkg::word_t    dmem_rdata,
    output logic              dmem_we,
    output logic              dmem_req,
    input  logic              dmem_ack,
    // debug register read
    input  cpu_pkg::reg_addr_t dbg_addr,
    output cpu_pkg::word_t    dbg_data
);
    import cpu_pkg::*;

    // fetch / decode
    word_t     pc_id;
    word_t     instr_id;
    logic      branch_taken;
    word_t     branch_target;
    logic      flush_id;
    reg_addr_t ra1_id;
    reg_addr_t ra2_id;
    logic      uses_rs2;
    logic      is_branch;
    // hazard control
    logic      stall_if;
    logic      stall_id;
    logic      stall_ex;
    logic      stall_mem;
    logic      flush_ex;
    bypass_e   fwd_a;
    bypass_e   fwd_b;
    logic      cmp_fwd_a;
    logic      cmp_fwd_b;
    logic      mem_done;
    // memory stage
    word_t     alu_res_mem;
    word_t     store_data_mem;
    reg_addr_t wa_mem;
    logic      we_rf_mem;
    logic      we_dm_mem;
    logic      is_load_mem;
    logic      mem_access;
    // writeback
    reg_addr_t wa_wb;
    word_t     wd_wb;
    logic      we_wb;

    de_bus_if de_bus ();

    fetch_unit fetch_unit0 (
        .clk, .arst_n, .stall_if, .flush_id, .branch_taken, .branch_target,
        .imem_addr, .imem_data, .pc_id, .instr_id
    );

    decode_unit decode_unit0 (
        .clk, .arst_n, .pc_id, .instr_id, .stall_id, .flush_ex, .stall_ex,
        .cmp_fwd_a, .cmp_fwd_b, .alu_res_mem, .wa_wb, .wd_wb, .we_wb,
        .dbg_addr, .dbg_data, .ra1_id, .ra2_id, .uses_rs2, .is_branch,
        .branch_taken, .branch_target, .flush_id,
        .de          (de_bus)
    );

    exec_unit exec_unit0 (
        .clk, .arst_n, .fwd_a, .fwd_b, .wd_wb, .stall_mem,
        .de          (de_bus),
        .alu_res_fb  (alu_res_mem), // memory-stage result fed back
        .alu_res_mem, .store_data_mem, .wa_mem, .we_rf_mem, .we_dm_mem, .is_load_mem
    );

    memwb_unit memwb_unit0 (
        .clk, .arst_n, .alu_res_mem, .store_data_mem, .wa_mem,
        .we_rf_mem, .we_dm_mem, .is_load_mem, .mem_done, .dmem_ack, .dmem_rdata,
        .dmem_addr, .dmem_wdata, .dmem_we, .mem_access, .wa_wb, .wd_wb, .we_wb
    );

    hazard_ctrl hazard_ctrl0 (
        .clk, .arst_n, .ra1_id, .ra2_id, .uses_rs2, .is_branch,
        .de          (de_bus),
        .wa_mem, .we_rf_mem, .mem_access, .wa_wb,
        .we_rf_wb    (we_wb),
        .dmem_ack, .dmem_req, .mem_done, .fwd_a, .fwd_b, .cmp_fwd_a, .cmp_fwd_b,
        .stall_if, .stall_id, .stall_ex, .stall_mem, .flush_ex
    );

endmodule : cpu_top

//--- bench/cpu_chk.sv
// data memory handshake and pipeline control assertions for the core
`timescale 1ns/1ps

module cpu_chk
(
    input logic                 clk,
    input logic                 arst_n,
    input logic                 dmem_req,
    input logic                 dmem_ack,
    input cpu_pkg::word_t       dmem_addr,
    input cpu_pkg::word_t       dmem_wdata,
    input logic                 dmem_we,
    input cpu_pkg::mem_state_e  mem_state,
    input logic                 stall_mem
);
    import cpu_pkg::*;

    // req is held until the memory answers
    req_until_ack: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_req && !dmem_ack |=> dmem_req)
        else $error("dmem_req dropped before dmem_ack");

    no_req_rise_on_ack: assert property (@(posedge clk) disable iff (!arst_n)
        !dmem_req && dmem_ack |=> !dmem_req)
        else $error("dmem_req raised while dmem_ack was still high");

    // request fields frozen while waiting for ack
    req_fields_stable: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_req && !dmem_ack |=> $stable(dmem_addr) && $stable(dmem_wdata) && $stable(dmem_we))
        else $error("dmem_addr, dmem_wdata or dmem_we changed during a request");

    req_low_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !dmem_req)
        else $error("dmem_req high in the first cycle after reset");

    ack_only_when_open: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_ack |-> mem_state != M_IDLE)
        else $error("dmem_ack seen with no access open");

    // memory stage holds its access while the request is open
    req_holds_mem_stage: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_req |-> stall_mem)
        else $error("memory stage not stalled during an open request");

endmodule : cpu_chk

bind cpu_top cpu_chk chk0 (
    .clk,
    .arst_n,
    .dmem_req,
    .dmem_ack,
    .dmem_addr,
    .dmem_wdata,
    .dmem_we,
    .mem_state (hazard_ctrl0.mem_state),
    .stall_mem
);

//--- bench/tb_cpu.sv
// testbench for the pipelined core driven by program and expected results from the tests file
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int MEM_WORDS     = 64;
    localparam int HALT_ARRIVALS = 4;    // halt loop entries before the pipeline counts as drained
    localparam int HALT_TIMEOUT  = 3000; // cycles

    logic      clk        = 1'b0;
    logic      arst_n     = 1'b0;
    word_t     imem_addr;
    word_t     imem_data  = NOP_INSTR;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    word_t     dmem_rdata = '0;
    logic      dmem_we;
    logic      dmem_req;
    logic      dmem_ack   = 1'b0;
    reg_addr_t dbg_addr   = '0;
    word_t     dbg_data;

    word_t       imem [MEM_WORDS];
    word_t       dmem [MEM_WORDS];
    word_t       halt_addr;
    reg_addr_t   exp_reg_idx [$];
    word_t       exp_reg_val [$];
    word_t       exp_mem_addr [$];
    word_t       exp_mem_val [$];
    logic [31:0] lfsr = 32'h0bfd_a2c8;
    logic        ack_armed = 1'b0; // delay already drawn for this request
    logic [1:0]  ack_delay = '0;
    logic        ack_linger = 1'b0; // ack stays one more cycle after req falls

    cpu_top dut0 (
        .clk,
        .arst_n,
        .imem_addr,
        .imem_data,
        .dmem_addr,
        .dmem_wdata,
        .dmem_rdata,
        .dmem_we,
        .dmem_req,
        .dmem_ack,
        .dbg_addr,
        .dbg_data
    );

    always #20 clk = ~clk;

    // galois step with taps for x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            lfsr_next = (state >> 1) ^ 32'h8020_0003;
        else
            lfsr_next = state >> 1;
    endfunction

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_reg(input reg_addr_t idx, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t: x%0d reads %h, expected %h", $time, idx, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_mem(input word_t addr, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t: memory at %h holds %h, expected %h",
                     $time, addr, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        int          ch;
        logic [63:0] tag;
        word_t       a;
        word_t       v;
        fd = $fopen("bench/cpu_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the tests file bench/cpu_tests.txt");
            stop_with_failure();
        end
        while (!$feof(fd))
        begin
            n = $fscanf(fd, "%s", tag);
            if (n == 1)
            begin
                if (tag[7:0] == "#")
                begin
                    ch = $fgetc(fd); // rest of a comment line
                    while (ch != 10 && ch != -1)
                        ch = $fgetc(fd);
                end
                else
                begin
                    n = $fscanf(fd, "%h %h", a, v);
                    if (n != 2)
                    begin
                        $display("malformed entry in the tests file");
                        stop_with_failure();
                    end
                    case (tag[7:0])
                        "I":
                        begin
                            imem[a[7:2]] = v;
                            halt_addr    = a; // last program word is the halt loop
                        end
                        "R":
                        begin
                            exp_reg_idx.push_back(a[4:0]);
                            exp_reg_val.push_back(v);
                        end
                        "M":
                        begin
                            exp_mem_addr.push_back(a);
                            exp_mem_val.push_back(v);
                        end
                        default:
                        begin
                            $display("unknown entry tag in the tests file");
                            stop_with_failure();
                        end
                    endcase
                end
            end
        end
        $fclose(fd);
    endtask

    // instruction memory drives the word before the next rising edge
    always @(negedge clk)
        imem_data <= imem[imem_addr[7:2]];

    // data memory with four-phase handshake and 0 to 3 cycles before ack
    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                dmem[i] = 32'hd00d_0000 + i * 4;
            dmem_ack   <= 1'b0;
            dmem_rdata <= '0;
            ack_armed   = 1'b0;
            ack_linger  = 1'b0;
        end
        else if (dmem_ack)
        begin
            if (!dmem_req)
            begin
                if (ack_linger)
                    ack_linger = 1'b0; // late release
                else
                    dmem_ack <= 1'b0;
            end
        end
        else if (dmem_req)
        begin
            if (!ack_armed)
            begin
                for (int k = 0; k < 2; k++)
                begin
                    ack_delay = {ack_delay[0], lfsr[0]};
                    lfsr      = lfsr_next(lfsr);
                end
                ack_armed = 1'b1;
            end
            if (ack_delay == 2'd0)
            begin
                if (dmem_we)
                    dmem[dmem_addr[7:2]] = dmem_wdata;
                dmem_rdata <= dmem[dmem_addr[7:2]];
                dmem_ack   <= 1'b1;
                ack_armed   = 1'b0;
                ack_linger  = lfsr[0];
                lfsr        = lfsr_next(lfsr);
            end
            else
                ack_delay = ack_delay - 2'd1;
        end
    end

    // a few returns to the halt loop mean everything older has retired
    task automatic wait_for_halt();
        int   cycles;
        int   arrivals;
        logic at_halt_q;
        cycles    = 0;
        arrivals  = 0;
        at_halt_q = 1'b0;
        while (arrivals < HALT_ARRIVALS)
        begin
            @(negedge clk);
            if (imem_addr == halt_addr && !at_halt_q)
                arrivals++;
            at_halt_q = (imem_addr == halt_addr);
            cycles++;
            if (cycles > HALT_TIMEOUT)
            begin
                $display("timeout while waiting for the program to reach its halt loop");
                stop_with_failure();
            end
        end
    endtask

    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            imem[i] = NOP_INSTR;
        load_tests();

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        wait_for_halt();

        for (int i = 0; i < exp_reg_idx.size(); i++)
        begin
            @(negedge clk);
            dbg_addr = exp_reg_idx[i];
            @(posedge clk);
            check_reg(exp_reg_idx[i], exp_reg_val[i], dbg_data);
        end

        for (int i = 0; i < exp_mem_addr.size(); i++)
            check_mem(exp_mem_addr[i], exp_mem_val[i], dmem[exp_mem_addr[i][7:2]]);

        $display("Everything OK");
        $finish;
    end

endmodule : tb_cpu

//--- files.f
verilog/cpu_pkg.sv
verilog/de_bus_if.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/exec_unit.sv
verilog/memwb_unit.sv
verilog/hazard_ctrl.sv
verilog/cpu_top.sv
bench/cpu_chk.sv
bench/tb_cpu.sv

//--- run.sh
#!/bin/sh
# build the core with its testbench, run it and grade the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cpu -f files.f -o tb_cpu_sim > "$LOG" 2>&1 &&
    ./obj_dir/tb_cpu_sim >> "$LOG" 2>&1 ||
    echo "Something failed" >> "$LOG"

grep -q "Something failed" "$LOG" && echo "simulation FAILED, see $LOG" && exit 1
echo "simulation passed"
exit 0

//--- bench/cpu_tests.txt
# I: program byte address and instruction word, R: register index and expected value
# M: data byte address and expected word, all hex, the last I entry is the halt loop
I 00 00500093
I 04 ffd00113
I 08 002081b3
I 0c 40118233
I 10 001272b3
I 14 0022e333
I 18 001123b3
I 1c 0020a433
I 20 00708013
I 24 04000493
I 28 0014a023
I 2c 0064a223
I 30 0004a503
I 34 001505b3
I 38 0044a603
I 3c 00c4a423
I 40 00c4a683
I 44 00108463
I 48 00100093
I 4c 00109463
I 50 00200793
I 54 00900813
I 58 00180463
I 5c 00300893
I 60 41080933
I 64 00090463
I 68 00700893
I 6c 0084a983
I 70 00299463
I 74 00b00a13
I 78 00000063
R 00 00000000
R 01 00000005
R 02 fffffffd
R 03 00000002
R 04 fffffffd
R 05 00000005
R 06 fffffffd
R 07 00000001
R 08 00000000
R 09 00000040
R 0a 00000005
R 0b 0000000a
R 0c fffffffd
R 0d d00d004c
R 0f 00000002
R 10 00000009
R 11 00000003
R 12 00000000
R 13 fffffffd
R 14 0000000b
M 40 00000005
M 44 fffffffd
M 48 fffffffd
